/* run_sim.sh */
#!/bin/sh
# builds the store buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_store_buffer -o sim_store_buffer
# the simulator exits non-zero on a failure, so the log gives the verdict
./obj_dir/sim_store_buffer > sim.log 2>&1 || true
cat sim.log
if grep -q "Finished with errors" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
	echo "simulation stopped without a result"
	exit 1
fi
echo "simulation passed"

/* sb_bus_pkg.sv */
/*
 * bus side types of the write buffer for the bus request, the bus
 * response and the fault codes reported when a store fails
 */
`include "sb_defines.svh"

package sb_bus_pkg;

	// one bus beat as the master drives it
	typedef struct packed {
		logic                    cyc;
		logic                    stb;
		logic                    we;
		// byte lanes of the 16-byte line
		logic [`SB_BUS_SELW-1:0] sel;
		// always line aligned
		logic [`SB_AW-1:0]       adr;
		logic [`SB_BUS_DW-1:0]   dat;
		logic [1:0]              ol;
	} bus_req_t;

	// any of these bits ends the current beat
	typedef struct packed {
		logic ack;
		logic err;
		logic tlbmiss;
		logic wrv;
	} bus_rsp_t;

	// fault codes in the width the exception logic expects
	typedef enum logic [7:0] {
		FLT_NONE = 8'h00,
		// data bus error
		FLT_DBE  = 8'h30,
		// the TLB had no translation for the line
		FLT_TLB  = 8'h31,
		// write to a protected page
		FLT_DWF  = 8'h32
	} fault_e;

endpackage

/* sb_defines.svh */
/*
 * sizes shared by the store write buffer for the queue, the tags,
 * the address and data paths and the 128-bit bus
 */
`ifndef SB_DEFINES_SVH
`define SB_DEFINES_SVH

// ========================================
// queue and tag sizes
// ========================================

// number of stores the write buffer can hold
`define SB_WB_DEPTH 7
// issue queue and reorder buffer slots that the one-hot tags range over
`define SB_QENTRIES 8
`define SB_RENTRIES 8
// binary tag widths as the ports deliver them
`define SB_QBITS 3
`define SB_RBITS 3

// ========================================
// address, data and bus widths
// ========================================

`define SB_AW 32
`define SB_DW 64
`define SB_SELW 8
`define SB_BUS_DW 128
`define SB_BUS_SELW 16
// the bus moves whole 16-byte lines and the line address starts at bit 4
`define SB_LINE_BYTES 16
`define SB_LINE_LSB 4

`endif

/* sb_store_pkg.sv */
/*
 * store side types of the write buffer for port requests, queue entries,
 * completions and the failed store handed back to the cache
 */
`include "sb_defines.svh"

package sb_store_pkg;

	// a store as a load/store port presents it with binary tags
	typedef struct packed {
		logic [`SB_QBITS-1:0] id;
		logic [`SB_RBITS-1:0] rid;
		// privilege level of the issuing instruction
		logic                 ol;
		logic [`SB_SELW-1:0]  sel;
		logic [`SB_AW-1:0]    adr;
		logic [`SB_DW-1:0]    dat;
	} store_req_t;

	// one slot of the write buffer queue
	// the tags are one-hot here so that completion needs no decoder
	typedef struct packed {
		logic [`SB_QENTRIES-1:0] uid;
		logic [`SB_RENTRIES-1:0] ruid;
		// privilege level widened to the bus format
		logic [1:0]              ol;
		logic [`SB_SELW-1:0]     sel;
		logic [`SB_AW-1:0]       adr;
		logic [`SB_DW-1:0]       dat;
	} wb_entry_t;

	// completion of a store that the bus accepted
	typedef struct packed {
		logic [`SB_QENTRIES-1:0] uid;
		logic [`SB_RENTRIES-1:0] ruid;
	} store_done_t;

	// store that failed on the bus and goes back to the cache
	typedef struct packed {
		logic [`SB_SELW-1:0] sel;
		logic [`SB_AW-1:0]   adr;
		logic [`SB_DW-1:0]   dat;
	} cache_wr_t;

endpackage

/* sim.f */
+incdir+.
sb_store_pkg.sv
sb_bus_pkg.sv
store_intake.sv
write_buffer_queue.sv
store_bus_master.sv
store_buffer_top.sv
tb_store_buffer.sv

/* store_buffer_top.sv */
/*
 * store write buffer of the memory stage with intake, queue and bus master
 */
`include "sb_defines.svh"

module store_buffer_top import sb_store_pkg::*, sb_bus_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              enable_i,
	// store ports
	input  logic              p0_wr_i,
	input  store_req_t        p0_req_i,
	output logic              p0_ack_o,
	input  logic              p1_wr_i,
	input  store_req_t        p1_req_i,
	output logic              p1_ack_o,
	// load lookups
	input  logic [`SB_AW-1:0] p0_ld_adr_i,
	input  logic [`SB_AW-1:0] p1_ld_adr_i,
	output logic              p0_hit_o,
	output logic              p1_hit_o,
	// bus
	input  logic              bus_busy_i,
	input  bus_rsp_t          bus_rsp_i,
	output bus_req_t          bus_req_o,
	// completion and fault
	output logic              enabled_o,
	output logic              done_o,
	output store_done_t       done_info_o,
	output logic              fault_o,
	output fault_e            fault_code_o,
	output cache_wr_t         cache_wr_o
);

	logic      push;
	wb_entry_t entry;
	logic      full;
	logic      pop;
	logic      flush;
	logic      head_valid;
	wb_entry_t head;

	store_intake u_intake (
		.clk_i(clk_i), .rst_i(rst_i),
		.p0_wr_i(p0_wr_i), .p0_req_i(p0_req_i), .p0_ack_o(p0_ack_o),
		.p1_wr_i(p1_wr_i), .p1_req_i(p1_req_i), .p1_ack_o(p1_ack_o),
		.full_i(full), .enabled_i(enabled_o),
		.push_o(push), .entry_o(entry)
	);

	write_buffer_queue u_queue (
		.clk_i(clk_i), .rst_i(rst_i),
		.push_i(push), .entry_i(entry), .pop_i(pop), .flush_i(flush),
		.p0_ld_adr_i(p0_ld_adr_i), .p1_ld_adr_i(p1_ld_adr_i),
		.p0_hit_o(p0_hit_o), .p1_hit_o(p1_hit_o),
		.full_o(full), .head_valid_o(head_valid), .head_o(head)
	);

	store_bus_master u_master (
		.clk_i(clk_i), .rst_i(rst_i), .enable_i(enable_i),
		.head_valid_i(head_valid), .head_i(head),
		.bus_busy_i(bus_busy_i), .bus_rsp_i(bus_rsp_i), .bus_req_o(bus_req_o),
		.pop_o(pop), .flush_o(flush), .enabled_o(enabled_o),
		.done_o(done_o), .done_info_o(done_info_o),
		.fault_o(fault_o), .fault_code_o(fault_code_o), .cache_wr_o(cache_wr_o)
	);

endmodule

/* store_bus_master.sv */
/*
 * bus master that drains the queue head onto the 128-bit bus in one or
 * two beats, retires it with a completion and handles store faults
 */
`include "sb_defines.svh"

module store_bus_master import sb_store_pkg::*, sb_bus_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        enable_i,
	input  logic        head_valid_i,
	input  wb_entry_t   head_i,
	input  logic        bus_busy_i,
	input  bus_rsp_t    bus_rsp_i,
	output bus_req_t    bus_req_o,
	output logic        pop_o,
	output logic        flush_o,
	output logic        enabled_o,
	output logic        done_o,
	output store_done_t done_info_o,
	output logic        fault_o,
	output fault_e      fault_code_o,
	output cache_wr_t   cache_wr_o
);

	typedef enum logic [1:0] {IDLE, ACK1, BEAT2, ACK2} state_e;

	state_e                      state;
	logic [`SB_LINE_LSB-1:0]     off;
	logic [2*`SB_BUS_SELW-1:0]   sel_shift;
	logic [2*`SB_BUS_DW-1:0]     dat_shift;
	// lanes and data left over for the next line
	logic [`SB_BUS_SELW-1:0]     sel_hi;
	logic [`SB_BUS_DW-1:0]       dat_hi;
	logic                        rsp_any;
	logic                        rsp_flt;
	logic                        start;
	logic                        ending;
	fault_e                      flt_code;

	// ========================================
	// lane alignment of the head store
	// ========================================

	// the byte offset in the line moves both the selects and the data
	// and whatever spills past lane 15 belongs to the next line
	assign off = head_i.adr[`SB_LINE_LSB-1:0];
	assign sel_shift = {{(2*`SB_BUS_SELW-`SB_SELW){1'b0}}, head_i.sel} << off;
	assign dat_shift = {{(2*`SB_BUS_DW-`SB_DW){1'b0}}, head_i.dat} << {off, 3'b000};

	assign rsp_any = bus_rsp_i.ack | bus_rsp_i.err | bus_rsp_i.tlbmiss | bus_rsp_i.wrv;
	assign rsp_flt = bus_rsp_i.err | bus_rsp_i.tlbmiss | bus_rsp_i.wrv;

	// the queue acts on pop or flush one edge late, so the head is stale
	// in the cycle after either of them
	assign start = head_valid_i & ~bus_busy_i & ~pop_o & ~flush_o;

	// a response ends the store unless a clean first beat has a second one due
	assign ending = rsp_any & ((state == ACK2) ||
		(state == ACK1 && (rsp_flt || sel_hi == '0)));

	// when several fault bits come together a TLB miss wins over a write
	// violation, which wins over a plain bus error
	always_comb begin
		if (bus_rsp_i.tlbmiss)
			flt_code = FLT_TLB;
		else if (bus_rsp_i.wrv)
			flt_code = FLT_DWF;
		else if (bus_rsp_i.err)
			flt_code = FLT_DBE;
		else
			flt_code = FLT_NONE;
	end

	// ========================================
	// bus FSM
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= IDLE;
			bus_req_o.cyc <= 1'b0;
			bus_req_o.stb <= 1'b0;
			bus_req_o.we <= 1'b0;
			pop_o <= 1'b0;
			flush_o <= 1'b0;
			done_o <= 1'b0;
			fault_o <= 1'b0;
			enabled_o <= 1'b1;
			fault_code_o <= FLT_NONE;
		end else begin
			pop_o <= 1'b0;
			flush_o <= 1'b0;
			done_o <= 1'b0;
			fault_o <= 1'b0;
			if (enable_i)
				enabled_o <= 1'b1;
			case (state)
				IDLE: if (start) begin
					bus_req_o.cyc <= 1'b1;
					bus_req_o.stb <= 1'b1;
					bus_req_o.we <= 1'b1;
					bus_req_o.sel <= sel_shift[`SB_BUS_SELW-1:0];
					bus_req_o.adr <= {head_i.adr[`SB_AW-1:`SB_LINE_LSB], {`SB_LINE_LSB{1'b0}}};
					bus_req_o.dat <= dat_shift[`SB_BUS_DW-1:0];
					bus_req_o.ol <= head_i.ol;
					sel_hi <= sel_shift[2*`SB_BUS_SELW-1:`SB_BUS_SELW];
					dat_hi <= dat_shift[2*`SB_BUS_DW-1:`SB_BUS_DW];
					state <= ACK1;
				end
				ACK1: if (rsp_any) begin
					// stb drops for one cycle even when the line continues
					bus_req_o.stb <= 1'b0;
					state <= ending ? IDLE : BEAT2;
				end
				BEAT2: begin
					bus_req_o.stb <= 1'b1;
					bus_req_o.sel <= sel_hi;
					bus_req_o.adr <= bus_req_o.adr + `SB_AW'(`SB_LINE_BYTES);
					bus_req_o.dat <= dat_hi;
					state <= ACK2;
				end
				ACK2: if (rsp_any) begin
					bus_req_o.stb <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase

			// the head is still in slot 0 here, so its tags and payload are read directly
			if (ending) begin
				bus_req_o.cyc <= 1'b0;
				bus_req_o.we <= 1'b0;
				bus_req_o.sel <= '0;
				if (rsp_flt) begin
					// drop every queued store and refuse new ones until enable_i
					flush_o <= 1'b1;
					fault_o <= 1'b1;
					enabled_o <= 1'b0;
					fault_code_o <= flt_code;
					cache_wr_o.sel <= head_i.sel;
					cache_wr_o.adr <= head_i.adr;
					cache_wr_o.dat <= head_i.dat;
				end else begin
					pop_o <= 1'b1;
					done_o <= 1'b1;
					done_info_o.uid <= head_i.uid;
					done_info_o.ruid <= head_i.ruid;
				end
			end
		end
	end

	// the strobe is only meaningful inside a bus cycle
	a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		bus_req_o.stb |-> bus_req_o.cyc)
		else $error("store_bus_master: stb without cyc");

endmodule

/* store_intake.sv */
/*
 * store intake that takes one store at a time from the two ports,
 * acks it and pushes it into the write buffer queue with one-hot tags
 */
module store_intake import sb_store_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       p0_wr_i,
	input  store_req_t p0_req_i,
	output logic       p0_ack_o,
	input  logic       p1_wr_i,
	input  store_req_t p1_req_i,
	output logic       p1_ack_o,
	input  logic       full_i,
	input  logic       enabled_i,
	output logic       push_o,
	output wb_entry_t  entry_o
);

	logic       p0_want;
	logic       p1_want;
	logic       take;
	store_req_t pick;
	wb_entry_t  conv;

	// a port whose ack is still high is about to drop its request
	assign p0_want = p0_wr_i & ~p0_ack_o;
	assign p1_want = p1_wr_i & ~p1_ack_o;

	// the queue counts a push only on the edge after push_o rises
	// so a gap cycle follows each push and full_i is current when read
	assign take = (p0_want | p1_want) & enabled_i & ~full_i & ~push_o;

	// p0 wins when both ports ask in the same cycle
	assign pick = p0_want ? p0_req_i : p1_req_i;

	// binary tags become one-hot and ol is widened for the bus
	always_comb begin
		conv = '0;
		conv.uid[pick.id] = 1'b1;
		conv.ruid[pick.rid] = 1'b1;
		conv.ol = {1'b0, pick.ol};
		conv.sel = pick.sel;
		conv.adr = pick.adr;
		conv.dat = pick.dat;
	end

	// ack and push leave on the same edge
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			push_o <= 1'b0;
			p0_ack_o <= 1'b0;
			p1_ack_o <= 1'b0;
		end else begin
			push_o <= take;
			p0_ack_o <= take & p0_want;
			p1_ack_o <= take & ~p0_want;
		end
	end

	always_ff @(posedge clk_i) begin
		if (take)
			entry_o <= conv;
	end

	// the pushed store must always find a free slot in the queue
	a_push_not_full: assert property (@(posedge clk_i) disable iff (rst_i)
		push_o |-> !full_i)
		else $error("store_intake: push while the queue is full");

endmodule

/* tb_store_buffer.sv */
/*
 * directed testbench for the store write buffer with a bus responder,
 * an output monitor and a watchdog
 */
`include "sb_defines.svh"

module tb_store_buffer import sb_store_pkg::*, sb_bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS = 5;
	localparam int RESET_CYCLES = 8;

	logic              clk_i;
	logic              rst_i;
	logic              enable_i;
	logic              p0_wr_i;
	store_req_t        p0_req_i;
	logic              p0_ack_o;
	logic              p1_wr_i;
	store_req_t        p1_req_i;
	logic              p1_ack_o;
	logic [`SB_AW-1:0] p0_ld_adr_i;
	logic [`SB_AW-1:0] p1_ld_adr_i;
	logic              p0_hit_o;
	logic              p1_hit_o;
	logic              bus_busy_i;
	bus_rsp_t          bus_rsp_i;
	bus_req_t          bus_req_o;
	logic              enabled_o;
	logic              done_o;
	store_done_t       done_info_o;
	logic              fault_o;
	fault_e            fault_code_o;
	cache_wr_t         cache_wr_o;

	// the responder controls change only while no beat is waiting for its answer
	logic        stall = 1'b0;
	int          rsp_delay = 0;
	// response bits in the order ack, err, tlbmiss, wrv
	bus_rsp_t    rsp_kind = 4'b1000;
	logic [31:0] lcg_state = 32'h3c44_8e27;

	// what the bus and the outputs showed and what the store rules predict
	bus_req_t    beats [$];
	bus_req_t    exp_beats [$];
	store_done_t done_log [$];
	store_done_t exp_dones [$];
	fault_e      fault_codes [$];
	cache_wr_t   fault_wrs [$];
	int          ack_order [$];

	store_buffer_top dut0 (.*);

	// ========================================
	// clock, watchdog, responder, monitor
	// ========================================

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// every test fits well inside 2 us and the reset time comes on top
	initial begin
		#(NUM_TESTS * 2000 + RESET_CYCLES * 20);
		$display("watchdog expired before the tests were done");
		$display("Finished with errors");
		$fatal(1);
	end

	// answers each strobe after rsp_delay cycles and logs the beat it saw
	initial begin
		bus_rsp_i = '0;
		forever begin
			@(negedge clk_i);
			bus_rsp_i = '0;
			if (bus_req_o.stb && !stall) begin
				beats.push_back(bus_req_o);
				repeat (rsp_delay) @(negedge clk_i);
				bus_rsp_i = rsp_kind;
			end
		end
	end

	// the strobes are registered, so the falling edge sees them settled
	initial begin
		forever begin
			@(negedge clk_i);
			if (done_o)
				done_log.push_back(done_info_o);
			if (fault_o) begin
				fault_codes.push_back(fault_code_o);
				fault_wrs.push_back(cache_wr_o);
			end
			if (p0_ack_o)
				ack_order.push_back(0);
			if (p1_ack_o)
				ack_order.push_back(1);
		end
	end

	// ========================================
	// stimulus and expected values
	// ========================================

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// the test picks tags, lanes and address while data and privilege are random
	function automatic store_req_t make_req(input logic [`SB_QBITS-1:0] id,
			input logic [`SB_RBITS-1:0] rid, input logic [`SB_SELW-1:0] sel,
			input logic [`SB_AW-1:0] adr);
		store_req_t  r;
		logic [31:0] rnd;
		rnd = next_rand();
		r.id = id;
		r.rid = rid;
		r.ol = rnd[17];
		r.sel = sel;
		r.adr = adr;
		r.dat = {next_rand(), rnd};
		return r;
	endfunction

	// byte b of the store lands on lane offset+b, and lanes past 15 wrap
	// into a second beat at the next line
	function automatic void add_expected(input store_req_t r);
		bus_req_t    b1;
		bus_req_t    b2;
		store_done_t d;
		int          lane;
		b1 = '0;
		b1.cyc = 1'b1;
		b1.stb = 1'b1;
		b1.we = 1'b1;
		b1.ol = {1'b0, r.ol};
		b1.adr = {r.adr[`SB_AW-1:`SB_LINE_LSB], 4'h0};
		b2 = b1;
		b2.adr = b1.adr + 32'(`SB_LINE_BYTES);
		for (int b = 0; b < `SB_SELW; b++) begin
			lane = int'(r.adr[3:0]) + b;
			if (lane < `SB_BUS_SELW) begin
				b1.sel[lane] = r.sel[b];
				b1.dat[lane*8 +: 8] = r.dat[b*8 +: 8];
			end else begin
				b2.sel[lane - 16] = r.sel[b];
				b2.dat[(lane - 16)*8 +: 8] = r.dat[b*8 +: 8];
			end
		end
		exp_beats.push_back(b1);
		if (b2.sel != '0)
			exp_beats.push_back(b2);
		d.uid = 8'b1 << r.id;
		d.ruid = 8'b1 << r.rid;
		exp_dones.push_back(d);
	endfunction

	task automatic clear_logs();
		beats.delete();
		exp_beats.delete();
		done_log.delete();
		exp_dones.delete();
		fault_codes.delete();
		fault_wrs.delete();
		ack_order.delete();
	endtask

	// ========================================
	// checks
	// ========================================

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_beat(input bus_req_t got, input bus_req_t exp);
		if (got !== exp)
			fail_now($sformatf("FAIL bus_req_o got %h expected %h", got, exp));
	endtask

	task automatic check_done(input store_done_t got, input store_done_t exp);
		if (got !== exp)
			fail_now($sformatf("FAIL done_info_o got %h expected %h", got, exp));
	endtask

	task automatic check_fault(input fault_e got_code, input fault_e exp_code,
			input cache_wr_t got_wr, input cache_wr_t exp_wr);
		if (got_code !== exp_code)
			fail_now($sformatf("FAIL fault_code_o got %h expected %h", got_code, exp_code));
		if (got_wr !== exp_wr)
			fail_now($sformatf("FAIL cache_wr_o got %h expected %h", got_wr, exp_wr));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	// ========================================
	// port handshakes
	// ========================================

	task automatic raise_store(input int port, input store_req_t req);
		@(negedge clk_i);
		if (port == 0) begin
			p0_req_i = req;
			p0_wr_i = 1'b1;
		end else begin
			p1_req_i = req;
			p1_wr_i = 1'b1;
		end
	endtask

	// the request is held until its ack and dropped on that falling edge
	task automatic await_ack(input int port);
		logic got;
		got = 1'b0;
		while (!got) begin
			@(negedge clk_i);
			got = (port == 0) ? p0_ack_o : p1_ack_o;
		end
		if (port == 0)
			p0_wr_i = 1'b0;
		else
			p1_wr_i = 1'b0;
	endtask

	task automatic send_store(input int port, input store_req_t req);
		raise_store(port, req);
		await_ack(port);
	endtask

	task automatic expect_no_ack(input int port, input int cycles);
		repeat (cycles) begin
			@(negedge clk_i);
			check_bit(port == 0 ? "p0_ack_o" : "p1_ack_o",
				port == 0 ? p0_ack_o : p1_ack_o, 1'b0);
		end
	endtask

	task automatic wait_events(input int dones, input int faults);
		while (done_log.size() < dones || fault_codes.size() < faults)
			@(posedge clk_i);
	endtask

	// a few idle cycles show any stray beat or completion before comparing
	task automatic verify_results();
		repeat (6) @(negedge clk_i);
		check_bit("bus_req_o.cyc", bus_req_o.cyc, 1'b0);
		if (fault_codes.size() != 0)
			fail_now("a fault was reported although every store should complete");
		if (beats.size() != exp_beats.size())
			fail_now($sformatf("saw %0d bus beats where %0d were expected",
				beats.size(), exp_beats.size()));
		foreach (beats[i])
			check_beat(beats[i], exp_beats[i]);
		if (done_log.size() != exp_dones.size())
			fail_now($sformatf("saw %0d completions where %0d were expected",
				done_log.size(), exp_dones.size()));
		foreach (done_log[i])
			check_done(done_log[i], exp_dones[i]);
		clear_logs();
	endtask

	// ========================================
	// tests
	// ========================================

	task automatic aligned_stores();
		store_req_t r;
		clear_logs();
		rsp_delay = int'(next_rand() % 32'd3);
		r = make_req(3'd5, 3'd2, 8'h0f, 32'h1000_0040);
		add_expected(r);
		send_store(0, r);
		// offset 8 with all lanes still ends at lane 15
		r = make_req(3'd1, 3'd7, 8'hff, 32'h1000_0088);
		add_expected(r);
		send_store(0, r);
		wait_events(2, 0);
		verify_results();
	endtask

	task automatic line_crossing_store();
		store_req_t r;
		clear_logs();
		rsp_delay = int'(next_rand() % 32'd3);
		// the arbiter holds the bus, so the store has to wait in the queue
		@(negedge clk_i);
		bus_busy_i = 1'b1;
		r = make_req(3'd3, 3'd6, 8'hff, 32'h2000_010c);
		add_expected(r);
		send_store(1, r);
		repeat (4) begin
			@(negedge clk_i);
			check_bit("bus_req_o.cyc", bus_req_o.cyc, 1'b0);
		end
		bus_busy_i = 1'b0;
		wait_events(1, 0);
		verify_results();
	endtask

	task automatic dual_port_order();
		store_req_t ra;
		store_req_t rb;
		clear_logs();
		rsp_delay = int'(next_rand() % 32'd3);
		ra = make_req(3'd0, 3'd1, 8'hff, 32'h3000_0004);
		// lanes 14 to 17 so the p1 store needs two beats
		rb = make_req(3'd7, 3'd4, 8'hf0, 32'h3000_002a);
		add_expected(ra);
		add_expected(rb);
		fork
			send_store(0, ra);
			send_store(1, rb);
		join
		wait_events(2, 0);
		if (ack_order.size() != 2)
			fail_now("the two ports were not acked once each");
		check_bit("p0_ack_o", logic'(ack_order[0] == 0), 1'b1);
		verify_results();
	endtask

	task automatic full_queue_stall();
		store_req_t r;
		clear_logs();
		rsp_delay = 1;
		@(posedge clk_i);
		stall = 1'b1;
		for (int i = 0; i < `SB_WB_DEPTH; i++) begin
			r = make_req(3'(i), 3'(i + 1), 8'hff, 32'h4000_0000 + 32'(i) * 32'h100);
			add_expected(r);
			send_store(0, r);
		end
		// p0 looks into the line of the third store, p1 into a line never written
		@(negedge clk_i);
		p0_ld_adr_i = 32'h4000_0208;
		p1_ld_adr_i = 32'h4000_0800;
		@(negedge clk_i);
		check_bit("p0_hit_o", p0_hit_o, 1'b1);
		check_bit("p1_hit_o", p1_hit_o, 1'b0);
		r = make_req(3'd7, 3'd0, 8'h3c, 32'h4000_0904);
		add_expected(r);
		raise_store(1, r);
		expect_no_ack(1, 10);
		@(posedge clk_i);
		stall = 1'b0;
		await_ack(1);
		if (done_log.size() == 0)
			fail_now("p1 was acked while the queue was still full");
		wait_events(`SB_WB_DEPTH + 1, 0);
		verify_results();
	endtask

	task automatic fault_recovery();
		bus_rsp_t   kinds [4];
		fault_e     codes [4];
		store_req_t a;
		store_req_t b;
		store_req_t c;
		cache_wr_t  wr;
		kinds[0] = 4'b0100;
		codes[0] = FLT_DBE;
		kinds[1] = 4'b0010;
		codes[1] = FLT_TLB;
		kinds[2] = 4'b0001;
		codes[2] = FLT_DWF;
		// a TLB miss outranks a write violation in the same response
		kinds[3] = 4'b0011;
		codes[3] = FLT_TLB;
		for (int k = 0; k < 4; k++) begin
			clear_logs();
			rsp_delay = int'(next_rand() % 32'd3);
			@(posedge clk_i);
			stall = 1'b1;
			rsp_kind = kinds[k];
			// store a crosses a line, so the fault also cancels its second beat
			a = make_req(3'(k), 3'(k + 2), 8'hff, 32'h5000_000c + 32'(k) * 32'h40);
			b = make_req(3'(k + 4), 3'(k), 8'h01, 32'h5000_0020 + 32'(k) * 32'h40);
			send_store(0, a);
			send_store(1, b);
			@(negedge clk_i);
			p0_ld_adr_i = b.adr;
			p1_ld_adr_i = a.adr;
			@(negedge clk_i);
			check_bit("p0_hit_o", p0_hit_o, 1'b1);
			check_bit("p1_hit_o", p1_hit_o, 1'b1);
			@(posedge clk_i);
			stall = 1'b0;
			wait_events(0, 1);
			repeat (4) @(negedge clk_i);
			// the flush leaves no line pending
			check_bit("p0_hit_o", p0_hit_o, 1'b0);
			check_bit("p1_hit_o", p1_hit_o, 1'b0);
			wr.sel = a.sel;
			wr.adr = a.adr;
			wr.dat = a.dat;
			check_fault(fault_codes[0], codes[k], fault_wrs[0], wr);
			add_expected(a);
			if (beats.size() != 1 || done_log.size() != 0 || fault_codes.size() != 1)
				fail_now("the faulting store did not end with exactly one beat and one fault");
			check_beat(beats[0], exp_beats[0]);
			clear_logs();
			rsp_kind = 4'b1000;
			c = make_req(3'(k + 1), 3'(k + 3), 8'h81, 32'h5000_0104 + 32'(k) * 32'h40);
			add_expected(c);
			raise_store(0, c);
			expect_no_ack(0, 5);
			check_bit("enabled_o", enabled_o, 1'b0);
			@(negedge clk_i);
			enable_i = 1'b1;
			@(negedge clk_i);
			enable_i = 1'b0;
			await_ack(0);
			wait_events(1, 0);
			verify_results();
		end
	endtask

	initial begin
		rst_i = 1'b1;
		enable_i = 1'b0;
		p0_wr_i = 1'b0;
		p0_req_i = '0;
		p1_wr_i = 1'b0;
		p1_req_i = '0;
		p0_ld_adr_i = '0;
		p1_ld_adr_i = '0;
		bus_busy_i = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk_i);
		rst_i = 1'b0;
		aligned_stores();
		line_crossing_store();
		dual_port_order();
		full_queue_stall();
		fault_recovery();
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* write_buffer_queue.sv */
/*
 * in-order store queue built as a shift register, with the head for the
 * bus master, a full flag for the intake and line hits for the loads
 */
`include "sb_defines.svh"

module write_buffer_queue import sb_store_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              push_i,
	input  wb_entry_t         entry_i,
	input  logic              pop_i,
	input  logic              flush_i,
	input  logic [`SB_AW-1:0] p0_ld_adr_i,
	input  logic [`SB_AW-1:0] p1_ld_adr_i,
	output logic              p0_hit_o,
	output logic              p1_hit_o,
	output logic              full_o,
	output logic              head_valid_o,
	output wb_entry_t         head_o
);

	localparam int DEPTH = `SB_WB_DEPTH;
	localparam int PW = $clog2(DEPTH + 1);

	// slot 0 is always the oldest store
	wb_entry_t        q [DEPTH];
	logic [DEPTH-1:0] v;
	// first free slot, equal to the number of stores held
	logic [PW-1:0]    wr_ptr;
	// slot the pushed store lands in once a pop in the same cycle shifts
	logic [PW-1:0]    ins_ptr;

	assign ins_ptr = pop_i ? wr_ptr - PW'(1) : wr_ptr;

	// ========================================
	// control state
	// ========================================

	// a flush drops every store, and a push in that cycle goes with them
	always_ff @(posedge clk_i) begin
		if (rst_i || flush_i) begin
			v <= '0;
			wr_ptr <= '0;
		end else begin
			// shift the valid bits first so that a push into the freed
			// slot overrides the bit that shifted in
			if (pop_i)
				v <= {1'b0, v[DEPTH-1:1]};
			if (push_i)
				v[ins_ptr] <= 1'b1;
			wr_ptr <= wr_ptr + PW'(push_i) - PW'(pop_i);
		end
	end

	// ========================================
	// store slots
	// ========================================

	always_ff @(posedge clk_i) begin
		if (pop_i) begin
			for (int i = 0; i < DEPTH - 1; i++)
				q[i] <= q[i + 1];
		end
		if (push_i)
			q[ins_ptr] <= entry_i;
	end

	assign full_o = (wr_ptr == PW'(DEPTH));
	assign head_valid_o = v[0];
	assign head_o = q[0];

	// ========================================
	// load hit detection
	// ========================================

	// a load whose line still has a store pending must wait for the bus
	// so the cache is not read before the store lands
	always_comb begin
		p0_hit_o = 1'b0;
		p1_hit_o = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (v[i] && q[i].adr[`SB_AW-1:`SB_LINE_LSB] ==
					p0_ld_adr_i[`SB_AW-1:`SB_LINE_LSB])
				p0_hit_o = 1'b1;
			if (v[i] && q[i].adr[`SB_AW-1:`SB_LINE_LSB] ==
					p1_ld_adr_i[`SB_AW-1:`SB_LINE_LSB])
				p1_hit_o = 1'b1;
		end
	end

	// the bus master only retires a store it took from a valid head
	a_pop_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
		pop_i |-> v[0])
		else $error("write_buffer_queue: pop from an empty queue");

endmodule
